// ==== hdl/rvCorePkg.sv ====
// rv32i core package with word types, alu codes, access widths and pipeline structs
`default_nettype none

package rvCorePkg;

  // data, address and instruction word
  typedef logic [31:0] xlenWord;
  // architectural register number
  typedef logic [4:0]  regIdx;
  // alu operation select
  typedef logic [3:0]  aluOpT;
  // load and store access size
  typedef logic [1:0]  memWidthT;

  // arithmetic and logic group
  localparam aluOpT ALU_ADD   = 4'd0;
  localparam aluOpT ALU_SUB   = 4'd1;
  localparam aluOpT ALU_SLL   = 4'd2;
  localparam aluOpT ALU_SLT   = 4'd3;
  localparam aluOpT ALU_SLTU  = 4'd4;
  localparam aluOpT ALU_XOR   = 4'd5;
  localparam aluOpT ALU_SRL   = 4'd6;
  localparam aluOpT ALU_SRA   = 4'd7;
  localparam aluOpT ALU_OR    = 4'd8;
  localparam aluOpT ALU_AND   = 4'd9;
  // lui result is the immediate itself
  localparam aluOpT ALU_PASSB = 4'd10;

  // branch compares reuse the low codes
  // only read when isBranch is set
  localparam aluOpT ALU_EQ    = 4'd0;
  localparam aluOpT ALU_NE    = 4'd1;
  localparam aluOpT ALU_LT    = 4'd2;
  localparam aluOpT ALU_GE    = 4'd3;
  localparam aluOpT ALU_LTU   = 4'd4;
  localparam aluOpT ALU_GEU   = 4'd5;

  // same encoding as funct3[1:0] of loads and stores
  localparam memWidthT MEM_BYTE = 2'd0;
  localparam memWidthT MEM_HALF = 2'd1;
  localparam memWidthT MEM_WORD = 2'd2;

  // decoder output for one instruction
  typedef struct packed {
    aluOpT    aluOp;
    memWidthT memWidth;
    regIdx    rd;
    regIdx    rs1;
    regIdx    rs2;
    xlenWord  imm;
    logic     regWen;
    logic     useImm;
    logic     usePc;
    logic     isBranch;
    logic     isJal;
    logic     isJalr;
    logic     isLoad;
    logic     isStore;
    logic     loadUnsigned;
    logic     isEbreak;
    logic     isIllegal;
  } decodedInst;

  // contents of the decode to execute register
  typedef struct packed {
    logic       valid;
    xlenWord    pc;
    decodedInst dec;
    xlenWord    rs1Val;
    xlenWord    rs2Val;
  } execBundle;

  // one register write as seen on the trace port
  typedef struct packed {
    logic    valid;
    xlenWord pc;
    regIdx   rd;
    xlenWord data;
  } retireInfo;

endpackage

`default_nettype wire

// ==== hdl/instDecoder.sv ====
// rv32i decoder producing alu selects, control flags, immediates and illegal detection
`default_nettype none

module instDecoder import rvCorePkg::*; (
  input  wire xlenWord inst,
  output decodedInst   dec
);

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  // the only system instruction kept
  localparam xlenWord    EBREAK    = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlenWord    immI;
  xlenWord    immS;
  xlenWord    immB;
  xlenWord    immU;
  xlenWord    immJ;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // immediates, all sign extended from bit 31
  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // funct3 to alu code, alt picks sub or sra
  function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arithOp = alt ? ALU_SUB : ALU_ADD;
      3'b001:  arithOp = ALU_SLL;
      3'b010:  arithOp = ALU_SLT;
      3'b011:  arithOp = ALU_SLTU;
      3'b100:  arithOp = ALU_XOR;
      3'b101:  arithOp = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arithOp = ALU_OR;
      default: arithOp = ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec              = '0;
    dec.rd           = inst[11:7];
    dec.rs1          = inst[19:15];
    dec.rs2          = inst[24:20];
    dec.aluOp        = ALU_ADD;
    // loads and stores carry size and sign in funct3
    dec.memWidth     = memWidthT'(funct3[1:0]);
    dec.loadUnsigned = funct3[2];
    case (opcode)
      OP_LUI: begin
        dec.imm    = immU;
        dec.useImm = 1'b1;
        dec.aluOp  = ALU_PASSB;
        dec.regWen = 1'b1;
      end
      OP_AUIPC: begin
        dec.imm    = immU;
        dec.useImm = 1'b1;
        dec.usePc  = 1'b1;
        dec.regWen = 1'b1;
      end
      OP_JAL: begin
        // alu forms the target, writeback takes pc+4
        dec.imm    = immJ;
        dec.useImm = 1'b1;
        dec.usePc  = 1'b1;
        dec.isJal  = 1'b1;
        dec.regWen = 1'b1;
      end
      OP_JALR: begin
        dec.imm       = immI;
        dec.useImm    = 1'b1;
        dec.isJalr    = 1'b1;
        dec.regWen    = 1'b1;
        dec.isIllegal = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        // alu compares rs1 with rs2
        dec.imm      = immB;
        dec.isBranch = 1'b1;
        case (funct3)
          3'b000:  dec.aluOp = ALU_EQ;
          3'b001:  dec.aluOp = ALU_NE;
          3'b100:  dec.aluOp = ALU_LT;
          3'b101:  dec.aluOp = ALU_GE;
          3'b110:  dec.aluOp = ALU_LTU;
          3'b111:  dec.aluOp = ALU_GEU;
          default: dec.isIllegal = 1'b1;
        endcase
      end
      OP_LOAD: begin
        dec.imm       = immI;
        dec.useImm    = 1'b1;
        dec.isLoad    = 1'b1;
        dec.regWen    = 1'b1;
        dec.isIllegal = funct3 inside {3'b011, 3'b110, 3'b111};
      end
      OP_STORE: begin
        dec.imm       = immS;
        dec.useImm    = 1'b1;
        dec.isStore   = 1'b1;
        dec.isIllegal = funct3[2] | (funct3[1:0] == 2'b11);
      end
      OP_IMM: begin
        dec.imm    = immI;
        dec.useImm = 1'b1;
        dec.regWen = 1'b1;
        // addi has no subtract form
        dec.aluOp  = arithOp(funct3, (funct3 == 3'b101) & funct7[5]);
        // shift immediates keep funct7 clean apart from the sra bit
        if (funct3 == 3'b001) begin
          dec.isIllegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          dec.isIllegal = !(funct7 inside {7'b0000000, 7'b0100000});
        end
      end
      OP_REG: begin
        dec.regWen    = 1'b1;
        dec.aluOp     = arithOp(funct3, funct7[5]);
        dec.isIllegal = (funct7 != 7'b0000000) &&
                        !((funct7 == 7'b0100000) && (funct3 inside {3'b000, 3'b101}));
      end
      OP_SYSTEM: begin
        // ecall and csr ops are not kept
        dec.isEbreak  = (inst == EBREAK);
        dec.isIllegal = (inst != EBREAK);
      end
      default: dec.isIllegal = 1'b1;
    endcase
    // unknown encodings must not touch state
    if (dec.isIllegal) begin
      dec.regWen  = 1'b0;
      dec.isStore = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
// integer register file with two asynchronous read ports and one write port
`default_nettype none

module regFile import rvCorePkg::*; (
  input  wire          clk,
  input  wire          rstN,
  input  wire regIdx   rs1,
  input  wire regIdx   rs2,
  input  wire regIdx   rd,
  input  wire          wen,
  input  wire xlenWord wdata,
  output xlenWord      rdata1,
  output xlenWord      rdata2
);

  xlenWord regs [32];

  // cleared on reset so every run starts from zeros
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // x0 reads as zero
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/execAlu.sv ====
// execute alu for arithmetic, logic, shifts, set-less-than and branch conditions
`default_nettype none

module execAlu import rvCorePkg::*; (
  input  wire xlenWord opA,
  input  wire xlenWord opB,
  input  wire aluOpT   aluOp,
  input  wire          isBranch,
  output xlenWord      result,
  output logic         takeBranch
);

  logic [4:0] shamt;
  logic       isEq;
  logic       isLt;
  logic       isLtu;

  // only the low five bits shift
  assign shamt = opB[4:0];
  assign isEq  = (opA == opB);
  assign isLt  = ($signed(opA) < $signed(opB));
  assign isLtu = (opA < opB);

  always_comb begin
    case (aluOp)
      ALU_ADD:   result = opA + opB;
      ALU_SUB:   result = opA - opB;
      ALU_SLL:   result = opA << shamt;
      ALU_SLT:   result = {31'b0, isLt};
      ALU_SLTU:  result = {31'b0, isLtu};
      ALU_XOR:   result = opA ^ opB;
      ALU_SRL:   result = opA >> shamt;
      ALU_SRA:   result = $signed(opA) >>> shamt;
      ALU_OR:    result = opA | opB;
      ALU_AND:   result = opA & opB;
      ALU_PASSB: result = opB;
      default:   result = '0;
    endcase
  end

  // compare group decoded only for branches
  always_comb begin
    case (aluOp)
      ALU_EQ:  takeBranch = isBranch & isEq;
      ALU_NE:  takeBranch = isBranch & ~isEq;
      ALU_LT:  takeBranch = isBranch & isLt;
      ALU_GE:  takeBranch = isBranch & ~isLt;
      ALU_LTU: takeBranch = isBranch & isLtu;
      ALU_GEU: takeBranch = isBranch & ~isLtu;
      default: takeBranch = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/dataMemory.sv ====
// word-wide data ram with byte-lane stores and sign or zero extended loads
`default_nettype none

module dataMemory import rvCorePkg::*; #(
  parameter int dmemWords = 256
) (
  input  wire           clk,
  input  wire xlenWord  addr,
  input  wire xlenWord  storeData,
  input  wire memWidthT memWidth,
  input  wire           isStore,
  input  wire           isLoad,
  input  wire           loadUnsigned,
  output xlenWord       loadData
);

  localparam int idxW = $clog2(dmemWords);

  xlenWord          mem [dmemWords];
  logic [idxW-1:0]  wordIdx;
  logic [3:0]       laneEn;
  xlenWord          laneData;
  xlenWord          rdWord;
  logic [7:0]       rdByte;
  logic [15:0]      rdHalf;

  // word address wraps around the array
  assign wordIdx = idxW'(addr[31:2] % dmemWords);

  // replicate the store value so any lane can take it
  always_comb begin
    case (memWidth)
      MEM_BYTE: begin
        laneEn   = 4'b0001 << addr[1:0];
        laneData = {4{storeData[7:0]}};
      end
      MEM_HALF: begin
        laneEn   = addr[1] ? 4'b1100 : 4'b0011;
        laneData = {2{storeData[15:0]}};
      end
      default: begin
        laneEn   = 4'b1111;
        laneData = storeData;
      end
    endcase
  end

  // written at the edge that ends execute
  always_ff @(posedge clk) begin
    if (isStore) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (laneEn[lane]) begin
          mem[wordIdx][8*lane +: 8] <= laneData[8*lane +: 8];
        end
      end
    end
  end

  // read side is combinational
  assign rdWord = mem[wordIdx];
  assign rdByte = rdWord[8*addr[1:0] +: 8];
  assign rdHalf = rdWord[16*addr[1] +: 16];

  always_comb begin
    case (memWidth)
      MEM_BYTE: loadData = loadUnsigned ? {24'b0, rdByte} : {{24{rdByte[7]}}, rdByte};
      MEM_HALF: loadData = loadUnsigned ? {16'b0, rdHalf} : {{16{rdHalf[15]}}, rdHalf};
      default:  loadData = rdWord;
    endcase
    // quiet bus when no load is executing
    if (!isLoad) begin
      loadData = '0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
// fetch stage with program counter, redirect and halt control, and the fetch-to-decode register
`default_nettype none

module fetchUnit import rvCorePkg::*; #(
  parameter xlenWord resetPc = '0
) (
  input  wire          clk,
  input  wire          rstN,
  input  wire          redirect,
  input  wire xlenWord redirectPc,
  input  wire          haltReq,
  output xlenWord      imemAddr,
  input  wire xlenWord imemData,
  output xlenWord      fetchPc,
  output xlenWord      fetchInst,
  output logic         fetchValid,
  output logic         halted
);

  xlenWord pc;
  logic    frozen;

  // halt request freezes the pc at the same edge it sets halted
  assign frozen   = halted | haltReq;
  assign imemAddr = pc;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc         <= resetPc;
      halted     <= 1'b0;
      fetchValid <= 1'b0;
    end else begin
      if (frozen) begin
        pc <= pc;
      end else if (redirect) begin
        pc <= redirectPc;
      end else begin
        pc <= pc + 32'd4;
      end
      // sticky until reset
      if (haltReq) begin
        halted <= 1'b1;
      end
      // wrong-path fetch becomes a bubble
      fetchValid <= !(redirect || frozen);
    end
  end

  // instruction and its pc move to decode every cycle
  always_ff @(posedge clk) begin
    fetchPc   <= pc;
    fetchInst <= imemData;
  end

endmodule

`default_nettype wire

// ==== hdl/rvCoreTop.sv ====
// three-stage rv32i core top with decode-to-execute register, forwarding and trace port
`default_nettype none

module rvCoreTop import rvCorePkg::*; #(
  parameter xlenWord resetPc   = '0,
  parameter int      dmemWords = 256
) (
  input  wire          clk,
  input  wire          rstN,
  output xlenWord      imemAddr,
  input  wire xlenWord imemData,
  output retireInfo    retire,
  output logic         halted,
  output logic         illegal
);

  // fetch and decode side
  xlenWord    fetchPc;
  xlenWord    fetchInst;
  logic       fetchValid;
  decodedInst idDec;
  xlenWord    rfData1;
  xlenWord    rfData2;
  xlenWord    fwdData1;
  xlenWord    fwdData2;
  logic       exWrites;

  // execute side
  execBundle  exNext;
  execBundle  ex;
  xlenWord    opA;
  xlenWord    opB;
  xlenWord    aluResult;
  logic       takeBranch;
  xlenWord    loadData;
  xlenWord    wbData;
  logic       wbEn;
  logic       redirect;
  xlenWord    redirectPc;
  logic       haltReq;

  fetchUnit #(
    .resetPc (resetPc)
  ) uFetch (
    .clk        (clk),
    .rstN       (rstN),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .haltReq    (haltReq),
    .imemAddr   (imemAddr),
    .imemData   (imemData),
    .fetchPc    (fetchPc),
    .fetchInst  (fetchInst),
    .fetchValid (fetchValid),
    .halted     (halted)
  );

  instDecoder uDecoder (
    .inst (fetchInst),
    .dec  (idDec)
  );

  // read in decode, written back at the end of execute
  regFile uRegFile (
    .clk    (clk),
    .rstN   (rstN),
    .rs1    (idDec.rs1),
    .rs2    (idDec.rs2),
    .rd     (ex.dec.rd),
    .wen    (wbEn),
    .wdata  (wbData),
    .rdata1 (rfData1),
    .rdata2 (rfData2)
  );

  // bypass the write still in flight in execute
  assign exWrites = wbEn && (ex.dec.rd != '0);
  assign fwdData1 = (exWrites && (ex.dec.rd == idDec.rs1)) ? wbData : rfData1;
  assign fwdData2 = (exWrites && (ex.dec.rd == idDec.rs2)) ? wbData : rfData2;

  // decode slot is wrong path on redirect or halt
  assign exNext = '{
    valid:  fetchValid && !redirect && !haltReq,
    pc:     fetchPc,
    dec:    idDec,
    rs1Val: fwdData1,
    rs2Val: fwdData2
  };

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ex <= '0;
    end else begin
      ex <= exNext;
    end
  end

  // pc feeds auipc and jal, imm replaces rs2 when flagged
  assign opA = ex.dec.usePc  ? ex.pc      : ex.rs1Val;
  assign opB = ex.dec.useImm ? ex.dec.imm : ex.rs2Val;

  execAlu uAlu (
    .opA        (opA),
    .opB        (opB),
    .aluOp      (ex.dec.aluOp),
    .isBranch   (ex.dec.isBranch),
    .result     (aluResult),
    .takeBranch (takeBranch)
  );

  dataMemory #(
    .dmemWords (dmemWords)
  ) uDmem (
    .clk          (clk),
    .addr         (aluResult),
    .storeData    (ex.rs2Val),
    .memWidth     (ex.dec.memWidth),
    .isStore      (ex.valid && ex.dec.isStore),
    .isLoad       (ex.dec.isLoad),
    .loadUnsigned (ex.dec.loadUnsigned),
    .loadData     (loadData)
  );

  // link address, load value or alu result
  assign wbData = (ex.dec.isJal || ex.dec.isJalr) ? ex.pc + 32'd4 :
                  ex.dec.isLoad                   ? loadData :
                                                    aluResult;
  assign wbEn   = ex.valid && ex.dec.regWen;

  // jumps always leave, branches only when taken
  assign redirect   = ex.valid &&
                      (ex.dec.isJal || ex.dec.isJalr || (ex.dec.isBranch && takeBranch));
  // jalr target drops bit 0
  assign redirectPc = ex.dec.isBranch ? ex.pc + ex.dec.imm : {aluResult[31:1], 1'b0};

  assign haltReq = ex.valid && (ex.dec.isEbreak || ex.dec.isIllegal);

  // sticky, cleared only by reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      illegal <= 1'b0;
    end else if (ex.valid && ex.dec.isIllegal) begin
      illegal <= 1'b1;
    end
  end

  // one trace record per register write
  assign retire = '{
    valid: wbEn,
    pc:    ex.pc,
    rd:    ex.dec.rd,
    data:  wbData
  };

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
// testbench clock and reset source with a 20 ns clock and a 10 cycle reset
`default_nettype none

module tbClock (
  input  wire  resetReq,
  output logic clk,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 1ps;

  int lowCycles;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset edges land on the falling clock edge
  initial begin
    rstN      = 1'b0;
    lowCycles = 10;
    forever begin
      @(negedge clk);
      // a request restarts the low phase
      if (resetReq) begin
        lowCycles = 10;
      end
      if (lowCycles > 0) begin
        rstN      = 1'b0;
        lowCycles = lowCycles - 1;
      end else begin
        rstN = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/rvCoreTb.sv ====
// testbench for the rv32i core with directed programs checked against the retire trace
`default_nettype none

module rvCoreTb import rvCorePkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_AUIPC   = 7'b0010111;
  localparam logic [6:0] OP_JALR    = 7'b1100111;
  localparam logic [6:0] OP_LOAD    = 7'b0000011;
  localparam logic [6:0] OP_IMM     = 7'b0010011;
  localparam xlenWord    EBREAK     = 32'h0010_0073;
  localparam int         IMEM_WORDS = 1024;

  logic      clk;
  logic      rstN;
  logic      resetReq;
  xlenWord   imemAddr;
  xlenWord   imemData;
  retireInfo retire;
  logic      halted;
  logic      illegal;

  xlenWord   imem [IMEM_WORDS];
  retireInfo traceQ [$];
  retireInfo expQ [$];
  int        progLen;
  xlenWord   haltPc;
  xlenWord   lfsrState;
  int        errorCount;
  int        testCount;
  int        failedTests;
  // grows with every program that is loaded
  int        budgetCycles = 40;

  tbClock uClock (
    .resetReq (resetReq),
    .clk      (clk),
    .rstN     (rstN)
  );

  rvCoreTop #(
    .resetPc   (32'h0),
    .dmemWords (256)
  ) UUT (
    .clk      (clk),
    .rstN     (rstN),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .retire   (retire),
    .halted   (halted),
    .illegal  (illegal)
  );

  // combinational fetch port
  assign imemData = imem[imemAddr[11:2]];

  // retire port is stable between rising edges
  always @(negedge clk) begin
    if (retire.valid) begin
      traceQ.push_back(retire);
    end
  end

  // galois lfsr with taps from x^32 + x^22 + x^2 + x + 1
  function automatic xlenWord lfsrNext(input xlenWord s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic xlenWord randomBits(input int n);
    xlenWord v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic xlenWord signExtend8(input logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  function automatic xlenWord signExtend16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // instruction formats
  function automatic xlenWord encodeR(input logic [6:0] f7, input regIdx rs2, input regIdx rs1,
                                      input logic [2:0] f3, input regIdx rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic xlenWord encodeI(input logic [11:0] imm, input regIdx rs1,
                                      input logic [2:0] f3, input regIdx rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic xlenWord encodeS(input logic [11:0] imm, input regIdx rs2, input regIdx rs1,
                                      input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic xlenWord encodeB(input logic [12:0] imm, input regIdx rs2, input regIdx rs1,
                                      input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic xlenWord encodeU(input logic [19:0] imm, input regIdx rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic xlenWord encodeJ(input logic [20:0] imm, input regIdx rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic xlenWord currentPc();
    return xlenWord'(4 * progLen);
  endfunction

  task automatic checkValue(input string what, input xlenWord got, input xlenWord want);
    assert (got == want) else begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", what, got, want);
      errorCount++;
    end
  endtask

  // unused words hold illegal opcodes tagged with their own index
  task automatic startProgram();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {15'd0, i[9:0], 7'h7f};
    end
    progLen = 0;
    expQ.delete();
  endtask

  task automatic emit(input xlenWord inst);
    imem[progLen] = inst;
    progLen++;
  endtask

  // instruction that stops the core
  task automatic emitHalt(input xlenWord inst);
    haltPc = currentPc();
    emit(inst);
  endtask

  // instruction expected to show up on the trace
  task automatic emitRetire(input xlenWord inst, input regIdx rd, input xlenWord data);
    retireInfo rec;
    rec.valid = 1'b1;
    rec.pc    = currentPc();
    rec.rd    = rd;
    rec.data  = data;
    expQ.push_back(rec);
    emit(inst);
  endtask

  // lui plus addi with the upper part rounded for the signed low half
  task automatic loadConst(input regIdx rd, input xlenWord v);
    logic [19:0] upper;
    upper = v[31:12] + 20'(v[11]);
    emitRetire(encodeU(upper, rd, OP_LUI), rd, {upper, 12'h000});
    emitRetire(encodeI(v[11:0], rd, 3'b000, rd, OP_IMM), rd, v);
  endtask

  task automatic resetCore();
    traceQ.delete();
    @(negedge clk);
    resetReq <= 1'b1;
    @(negedge clk);
    resetReq <= 1'b0;
    @(posedge clk);
    while (!rstN) begin
      @(posedge clk);
    end
    @(negedge clk);
    checkValue("halted after reset", xlenWord'(halted), 32'h0);
    checkValue("illegal after reset", xlenWord'(illegal), 32'h0);
  endtask

  task automatic runProgram(input string name, input logic expIllegal);
    int limit;
    int waited;
    int startErrors;
    int n;
    startErrors = errorCount;
    limit = progLen * 40;
    budgetCycles += limit + 20;
    resetCore();
    waited = 0;
    while (!halted && (waited < limit)) begin
      @(negedge clk);
      waited++;
    end
    assert (halted) else begin
      $display("test %s: core did not halt within %0d cycles", name, limit);
      errorCount++;
    end
    // a few more cycles so a late retire would be seen
    repeat (4) @(negedge clk);
    checkValue("illegal", xlenWord'(illegal), xlenWord'(expIllegal));
    // pc froze two words past the halting instruction
    checkValue("imemAddr after halt", imemAddr, haltPc + 32'd8);
    // monitor takes this falling edge before the trace is read
    @(posedge clk);
    checkValue("retire count", xlenWord'(traceQ.size()), xlenWord'(expQ.size()));
    n = (traceQ.size() < expQ.size()) ? traceQ.size() : expQ.size();
    for (int i = 0; i < n; i++) begin
      checkValue($sformatf("retire[%0d].pc", i), traceQ[i].pc, expQ[i].pc);
      checkValue($sformatf("retire[%0d].rd", i), xlenWord'(traceQ[i].rd), xlenWord'(expQ[i].rd));
      checkValue($sformatf("retire[%0d].data", i), traceQ[i].data, expQ[i].data);
    end
    testCount++;
    if (errorCount != startErrors) begin
      failedTests++;
    end
    $display("test %s: %0d errors", name, errorCount - startErrors);
  endtask

  task automatic aluTest();
    xlenWord     a;
    xlenWord     b;
    xlenWord     immV;
    logic [11:0] imm;
    logic [4:0]  sh;
    startProgram();
    a    = randomBits(32);
    b    = randomBits(32);
    imm  = 12'(randomBits(12));
    sh   = 5'(randomBits(5));
    immV = signExtend16({{4{imm[11]}}, imm});
    loadConst(1, a);
    loadConst(2, b);
    emitRetire(encodeR(7'h00, 2, 1, 3'b000, 3), 3, a + b);
    emitRetire(encodeR(7'h20, 2, 1, 3'b000, 4), 4, a - b);
    emitRetire(encodeR(7'h00, 2, 1, 3'b001, 5), 5, a << b[4:0]);
    emitRetire(encodeR(7'h00, 2, 1, 3'b010, 6), 6, {31'b0, $signed(a) < $signed(b)});
    emitRetire(encodeR(7'h00, 2, 1, 3'b011, 7), 7, {31'b0, a < b});
    emitRetire(encodeR(7'h00, 2, 1, 3'b100, 8), 8, a ^ b);
    emitRetire(encodeR(7'h00, 2, 1, 3'b101, 9), 9, a >> b[4:0]);
    emitRetire(encodeR(7'h20, 2, 1, 3'b101, 10), 10, xlenWord'($signed(a) >>> b[4:0]));
    emitRetire(encodeR(7'h00, 2, 1, 3'b110, 11), 11, a | b);
    emitRetire(encodeR(7'h00, 2, 1, 3'b111, 12), 12, a & b);
    emitRetire(encodeI(imm, 1, 3'b000, 13, OP_IMM), 13, a + immV);
    emitRetire(encodeI(imm, 1, 3'b010, 14, OP_IMM), 14, {31'b0, $signed(a) < $signed(immV)});
    emitRetire(encodeI(imm, 1, 3'b011, 15, OP_IMM), 15, {31'b0, a < immV});
    emitRetire(encodeI(imm, 1, 3'b100, 16, OP_IMM), 16, a ^ immV);
    emitRetire(encodeI(imm, 1, 3'b110, 17, OP_IMM), 17, a | immV);
    emitRetire(encodeI(imm, 1, 3'b111, 18, OP_IMM), 18, a & immV);
    emitRetire(encodeI({7'h00, sh}, 1, 3'b001, 19, OP_IMM), 19, a << sh);
    emitRetire(encodeI({7'h00, sh}, 1, 3'b101, 20, OP_IMM), 20, a >> sh);
    emitRetire(encodeI({7'h20, sh}, 1, 3'b101, 21, OP_IMM), 21, xlenWord'($signed(a) >>> sh));
    emitHalt(EBREAK);
    runProgram("alu", 1'b0);
  endtask

  // each result feeds the next instruction directly
  task automatic forwardTest();
    xlenWord c;
    xlenWord v2;
    xlenWord v3;
    xlenWord v4;
    xlenWord v5;
    startProgram();
    c  = randomBits(32);
    v2 = c + 32'd1;
    v3 = v2 + v2;
    v4 = v3 - c;
    v5 = v4 ^ v3;
    loadConst(1, c);
    emitRetire(encodeI(12'd1, 1, 3'b000, 2, OP_IMM), 2, v2);
    emitRetire(encodeR(7'h00, 2, 2, 3'b000, 3), 3, v3);
    emitRetire(encodeR(7'h20, 1, 3, 3'b000, 4), 4, v4);
    emitRetire(encodeR(7'h00, 3, 4, 3'b100, 5), 5, v5);
    emitRetire(encodeR(7'h00, 5, 5, 3'b000, 5), 5, v5 + v5);
    emitRetire(encodeR(7'h00, 5, 1, 3'b000, 7), 7, c + v5 + v5);
    // x0 write is traced but never forwarded
    emitRetire(encodeI(12'd5, 1, 3'b000, 0, OP_IMM), 0, c + 32'd5);
    emitRetire(encodeR(7'h00, 1, 0, 3'b000, 6), 6, c);
    emitHalt(EBREAK);
    runProgram("forward", 1'b0);
  endtask

  // x1 holds 5 and x2 holds -3 with one taken and one untaken branch per kind
  task automatic controlTest();
    logic [2:0] kinds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    regIdx      takenA [6] = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2};
    regIdx      takenB [6] = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
    regIdx      notA [6] = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
    regIdx      notB [6] = '{5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    xlenWord    poison;
    xlenWord    base;
    startProgram();
    poison = encodeI(12'd1, 0, 3'b000, 31, OP_IMM);
    emitRetire(encodeI(12'd5, 0, 3'b000, 1, OP_IMM), 1, 32'd5);
    emitRetire(encodeI(12'hffd, 0, 3'b000, 2, OP_IMM), 2, 32'hffff_fffd);
    for (int i = 0; i < 6; i++) begin
      emit(encodeB(13'd8, takenB[i], takenA[i], kinds[i]));
      emit(poison);
      emit(encodeB(13'd8, notB[i], notA[i], kinds[i]));
      emitRetire(encodeI(12'd1, 30, 3'b000, 30, OP_IMM), 30, xlenWord'(i + 1));
    end
    emitRetire(encodeU(20'h12345, 7, OP_AUIPC), 7, currentPc() + 32'h1234_5000);
    emitRetire(encodeJ(21'd12, 8), 8, currentPc() + 32'd4);
    emit(poison);
    emit(poison);
    base = currentPc();
    emitRetire(encodeU(20'h0, 9, OP_AUIPC), 9, base);
    // odd offset so the target lands past one poison word
    emitRetire(encodeI(12'd13, 9, 3'b000, 10, OP_JALR), 10, base + 32'd8);
    emit(poison);
    emitRetire(encodeI(12'd7, 0, 3'b000, 11, OP_IMM), 11, 32'd7);
    emitHalt(EBREAK);
    runProgram("control", 1'b0);
  endtask

  task automatic memoryTest();
    xlenWord w;
    xlenWord r;
    startProgram();
    w = randomBits(32);
    // force negative byte and half in the stored data
    r = randomBits(32) | 32'h0000_8080;
    emitRetire(encodeI(12'h100, 0, 3'b000, 1, OP_IMM), 1, 32'h100);
    loadConst(2, w);
    loadConst(3, r);
    emit(encodeS(12'd0, 2, 1, 3'b010));
    emit(encodeS(12'd1, 3, 1, 3'b000));
    // load right behind the store sees the merged byte
    emitRetire(encodeI(12'd0, 1, 3'b010, 4, OP_LOAD), 4, {w[31:16], r[7:0], w[7:0]});
    emit(encodeS(12'd4, 2, 1, 3'b010));
    emit(encodeS(12'd6, 3, 1, 3'b001));
    emitRetire(encodeI(12'd6, 1, 3'b001, 5, OP_LOAD), 5, signExtend16(r[15:0]));
    emitRetire(encodeI(12'd6, 1, 3'b101, 6, OP_LOAD), 6, {16'h0, r[15:0]});
    emitRetire(encodeI(12'd4, 1, 3'b001, 7, OP_LOAD), 7, signExtend16(w[15:0]));
    emitRetire(encodeI(12'd4, 1, 3'b010, 8, OP_LOAD), 8, {r[15:0], w[15:0]});
    emitRetire(encodeI(12'd1, 1, 3'b000, 9, OP_LOAD), 9, signExtend8(r[7:0]));
    emitRetire(encodeI(12'd1, 1, 3'b100, 10, OP_LOAD), 10, {24'h0, r[7:0]});
    emitRetire(encodeI(12'd3, 1, 3'b000, 11, OP_LOAD), 11, signExtend8(w[31:24]));
    emitRetire(encodeI(12'd0, 1, 3'b100, 12, OP_LOAD), 12, {24'h0, w[7:0]});
    emitHalt(EBREAK);
    runProgram("memory", 1'b0);
  endtask

  task automatic illegalTest();
    startProgram();
    emitRetire(encodeI(12'd3, 0, 3'b000, 1, OP_IMM), 1, 32'd3);
    // opcode zero is undefined
    emitHalt(32'h0000_0000);
    emit(encodeI(12'd2, 0, 3'b000, 2, OP_IMM));
    emit(EBREAK);
    runProgram("illegal", 1'b1);
  endtask

  // also checks that reset clears the flags left by the illegal test
  task automatic ebreakTest();
    startProgram();
    emitRetire(encodeI(12'd1, 0, 3'b000, 1, OP_IMM), 1, 32'd1);
    emitHalt(EBREAK);
    emit(encodeI(12'd2, 0, 3'b000, 2, OP_IMM));
    emit(encodeI(12'd3, 0, 3'b000, 3, OP_IMM));
    runProgram("ebreak", 1'b0);
  endtask

  initial begin
    int cycles;
    cycles = 0;
    while (cycles <= budgetCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog expired after %0d cycles before the tests finished", cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    resetReq    = 1'b0;
    lfsrState   = 32'd90;
    errorCount  = 0;
    testCount   = 0;
    failedTests = 0;
    startProgram();
    aluTest();
    forwardTest();
    controlTest();
    memoryTest();
    illegalTest();
    ebreakTest();
    $display("%0d tests run, %0d failed, %0d check errors", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/rvCorePkg.sv
hdl/instDecoder.sv
hdl/regFile.sv
hdl/execAlu.sv
hdl/dataMemory.sv
hdl/fetchUnit.sv
hdl/rvCoreTop.sv
testbench/tbClock.sv
testbench/rvCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)
